//--- alu.sv
module alu (
	input  logic [rvPkg::xlen-1:0] rdData1,
	input  logic [rvPkg::xlen-1:0] rdData2,
	input  logic [rvPkg::xlen-1:0] imm,
	input  logic aluSrcImm,
	input  logic [rvPkg::aluOpW-1:0] aluOp,
	output logic [rvPkg::xlen-1:0] result,
	output logic zero
);

	logic [rvPkg::xlen-1:0] opB;
	logic [4:0] shamt;

	assign opB = aluSrcImm ? imm : rdData2;
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			rvPkg::aluAdd: result = rdData1 + opB;
			rvPkg::aluSub: result = rdData1 - opB;
			rvPkg::aluAnd: result = rdData1 & opB;
			rvPkg::aluOr: result = rdData1 | opB;
			rvPkg::aluXor: result = rdData1 ^ opB;
			// signed compare
			rvPkg::aluSlt: begin
				result = {{(rvPkg::xlen - 1){1'b0}}, $signed(rdData1) < $signed(opB)};
			end
			rvPkg::aluSll: result = rdData1 << shamt;
			rvPkg::aluSrl: result = rdData1 >> shamt;
			// lui
			rvPkg::aluPassB: result = opB;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

	// decoder must always pick a defined operation
	always_comb begin
		assert (!$isunknown(aluOp))
			else $error("alu: operation code is unknown");
	end

endmodule

//--- compile.f
rvPkg.sv
pcUnit.sv
instDecoder.sv
registerFile.sv
alu.sv
memStage.sv
rvCore.sv
tbRvCore.sv

//--- instDecoder.sv
module instDecoder (
	input  rvPkg::rvInst inst,
	output logic [rvPkg::regAddrW-1:0] rs1,
	output logic [rvPkg::regAddrW-1:0] rs2,
	output logic [rvPkg::regAddrW-1:0] rd,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic aluSrcImm,
	output logic [rvPkg::aluOpW-1:0] aluOp,
	output logic [rvPkg::brKindW-1:0] branchKind,
	output logic [rvPkg::xlen-1:0] imm
);

	logic regWriteRaw;
	logic [rvPkg::xlen-1:0] immI;
	logic [rvPkg::xlen-1:0] immS;
	logic [rvPkg::xlen-1:0] immB;
	logic [rvPkg::xlen-1:0] immU;

	assign rs1 = inst.rType.rs1;
	assign rs2 = inst.rType.rs2;
	assign rd = inst.rType.rd;

	// immediates, one per format
	assign immI = {{(rvPkg::xlen - 12){inst.iType.imm12[11]}}, inst.iType.imm12};
	assign immS = {{(rvPkg::xlen - 12){inst.sType.immHi[6]}}, inst.sType.immHi,
		inst.sType.immLo};
	assign immB = {{(rvPkg::xlen - 12){inst.bType.immBit12}}, inst.bType.immLo[0],
		inst.bType.immBits10to5, inst.bType.immLo[4:1], 1'b0};
	assign immU = {inst.iType.imm12, inst.iType.rs1, inst.iType.funct3, 12'b0};

	always_comb begin
		regWriteRaw = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrcImm = 1'b0;
		aluOp = rvPkg::aluAdd;
		branchKind = rvPkg::brNone;
		imm = '0;
		case (inst.rType.opcode)
			rvPkg::opReg: begin
				regWriteRaw = 1'b1;
				case ({inst.rType.funct7, inst.rType.funct3})
					{rvPkg::funct7Base, rvPkg::f3AddSub}: aluOp = rvPkg::aluAdd;
					{rvPkg::funct7Sub, rvPkg::f3AddSub}: aluOp = rvPkg::aluSub;
					{rvPkg::funct7Base, rvPkg::f3Sll}: aluOp = rvPkg::aluSll;
					{rvPkg::funct7Base, rvPkg::f3Slt}: aluOp = rvPkg::aluSlt;
					{rvPkg::funct7Base, rvPkg::f3Xor}: aluOp = rvPkg::aluXor;
					{rvPkg::funct7Base, rvPkg::f3Srl}: aluOp = rvPkg::aluSrl;
					{rvPkg::funct7Base, rvPkg::f3Or}: aluOp = rvPkg::aluOr;
					{rvPkg::funct7Base, rvPkg::f3And}: aluOp = rvPkg::aluAnd;
					// sra, sltu and friends fall through as no-ops
					default: regWriteRaw = 1'b0;
				endcase
			end
			rvPkg::opImm: begin
				regWriteRaw = 1'b1;
				aluSrcImm = 1'b1;
				imm = immI;
				case (inst.iType.funct3)
					rvPkg::f3AddSub: aluOp = rvPkg::aluAdd;
					rvPkg::f3Slt: aluOp = rvPkg::aluSlt;
					rvPkg::f3Xor: aluOp = rvPkg::aluXor;
					rvPkg::f3Or: aluOp = rvPkg::aluOr;
					rvPkg::f3And: aluOp = rvPkg::aluAnd;
					default: regWriteRaw = 1'b0;
				endcase
			end
			rvPkg::opLoad: begin
				// word loads only
				if (inst.iType.funct3 == rvPkg::f3Word) begin
					regWriteRaw = 1'b1;
					memToReg = 1'b1;
					aluSrcImm = 1'b1;
					imm = immI;
				end
			end
			rvPkg::opStore: begin
				if (inst.sType.funct3 == rvPkg::f3Word) begin
					memWrite = 1'b1;
					aluSrcImm = 1'b1;
					imm = immS;
				end
			end
			rvPkg::opBranch: begin
				aluOp = rvPkg::aluSub;
				imm = immB;
				case (inst.bType.funct3)
					rvPkg::f3Beq: branchKind = rvPkg::brEq;
					rvPkg::f3Bne: branchKind = rvPkg::brNe;
					default: branchKind = rvPkg::brNone;
				endcase
			end
			rvPkg::opLui: begin
				regWriteRaw = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = rvPkg::aluPassB;
				imm = immU;
			end
			default: begin
			end
		endcase
	end

	// x0 is never a write target
	assign regWrite = regWriteRaw && (rd != '0);

endmodule

//--- memStage.sv
module memStage (
	input  logic clk,
	input  logic memWrite,
	input  logic memToReg,
	input  logic [rvPkg::xlen-1:0] aluResult,
	input  logic [rvPkg::xlen-1:0] storeData,
	output logic [rvPkg::xlen-1:0] wbData
);

	logic [rvPkg::xlen-1:0] mem [rvPkg::dmemWords];
	logic [rvPkg::dmemIdxW-1:0] wordIdx;

	// drop the byte offset, upper bits wrap
	assign wordIdx = aluResult[rvPkg::dmemIdxW+1:2];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[wordIdx] <= storeData;
		end
	end

	assign wbData = memToReg ? mem[wordIdx] : aluResult;

	// only word accesses exist, base plus offset must land on a word
	wordAligned: assert property (
		@(posedge clk) (memWrite || memToReg) |-> aluResult[1:0] == 2'b00)
		else $error("memStage: unaligned access at %h", aluResult);

endmodule

//--- pcUnit.sv
module pcUnit (
	input  logic clk,
	input  logic rstN,
	input  logic [rvPkg::brKindW-1:0] branchKind,
	input  logic zero,
	input  logic [rvPkg::xlen-1:0] imm,
	output logic [rvPkg::xlen-1:0] pc
);

	logic takeBranch;
	logic [rvPkg::xlen-1:0] pcNext;

	// zero comes from rs1 - rs2
	assign takeBranch = (branchKind == rvPkg::brEq && zero) ||
		(branchKind == rvPkg::brNe && !zero);

	assign pcNext = takeBranch ? pc + imm : pc + rvPkg::xlen'(4);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

	// a bad branch offset would show up here
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pcUnit: pc %h is not word aligned", pc);

endmodule

//--- registerFile.sv
module registerFile (
	input  logic clk,
	input  logic [rvPkg::regAddrW-1:0] rs1,
	input  logic [rvPkg::regAddrW-1:0] rs2,
	input  logic [rvPkg::regAddrW-1:0] rd,
	input  logic regWrite,
	input  logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] rdData1,
	output logic [rvPkg::xlen-1:0] rdData2
);

	logic [rvPkg::xlen-1:0] regs [2**rvPkg::regAddrW];

	always_ff @(posedge clk) begin
		if (regWrite) begin
			regs[rd] <= wdata;
		end
	end

	// entry 0 is never written, so mask it on the read side
	assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

	// the decoder already drops writes to x0
	noWriteX0: assert property (@(posedge clk) regWrite |-> rd != '0)
		else $error("registerFile: write request to x0");

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f compile.f --top-module tbRvCore

output=$(./obj_dir/VtbRvCore)
echo "$output"

echo "$output" | grep -q "^NO ERRORS$"

//--- rvCore.sv
module rvCore (
	input  logic clk,
	input  logic rstN,
	input  logic [rvPkg::xlen-1:0] imemData,
	output logic [rvPkg::xlen-1:0] imemAddr,
	output logic dmemWriteEn,
	output logic [rvPkg::xlen-1:0] dmemWriteAddr,
	output logic [rvPkg::xlen-1:0] dmemWriteData,
	output logic wbEn,
	output logic [rvPkg::regAddrW-1:0] wbAddr,
	output logic [rvPkg::xlen-1:0] wbData
);

	// decoder
	logic [rvPkg::regAddrW-1:0] rs1;
	logic [rvPkg::regAddrW-1:0] rs2;
	logic [rvPkg::regAddrW-1:0] rd;
	logic regWrite;
	logic memWrite;
	logic memToReg;
	logic aluSrcImm;
	logic [rvPkg::aluOpW-1:0] aluOp;
	logic [rvPkg::brKindW-1:0] branchKind;
	logic [rvPkg::xlen-1:0] imm;

	// datapath
	logic [rvPkg::xlen-1:0] pc;
	logic [rvPkg::xlen-1:0] rdData1;
	logic [rvPkg::xlen-1:0] rdData2;
	logic [rvPkg::xlen-1:0] aluResult;
	logic zero;

	// nothing commits while held in reset
	assign wbEn = regWrite & rstN;
	assign dmemWriteEn = memWrite & rstN;

	assign imemAddr = pc;
	assign wbAddr = rd;
	assign dmemWriteAddr = aluResult;
	assign dmemWriteData = rdData2;

	pcUnit pcUnitInst (
		.clk        (clk),
		.rstN       (rstN),
		.branchKind (branchKind),
		.zero       (zero),
		.imm        (imm),
		.pc         (pc)
	);

	instDecoder instDecoderInst (
		.inst       (imemData),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.regWrite   (regWrite),
		.memWrite   (memWrite),
		.memToReg   (memToReg),
		.aluSrcImm  (aluSrcImm),
		.aluOp      (aluOp),
		.branchKind (branchKind),
		.imm        (imm)
	);

	registerFile registerFileInst (
		.clk      (clk),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.regWrite (wbEn),
		.wdata    (wbData),
		.rdData1  (rdData1),
		.rdData2  (rdData2)
	);

	alu aluInst (
		.rdData1   (rdData1),
		.rdData2   (rdData2),
		.imm       (imm),
		.aluSrcImm (aluSrcImm),
		.aluOp     (aluOp),
		.result    (aluResult),
		.zero      (zero)
	);

	memStage memStageInst (
		.clk       (clk),
		.memWrite  (dmemWriteEn),
		.memToReg  (memToReg),
		.aluResult (aluResult),
		.storeData (rdData2),
		.wbData    (wbData)
	);

endmodule

//--- rvPkg.sv
package rvPkg;

	// widths
	localparam int xlen = 32;
	localparam int regAddrW = 5;
	localparam int dmemWords = 256;
	localparam int dmemIdxW = $clog2(dmemWords);
	localparam int opcodeW = 7;
	localparam int aluOpW = 4;
	localparam int brKindW = 2;

	// major opcodes of the supported subset
	localparam logic [opcodeW-1:0] opReg = 7'b0110011;
	localparam logic [opcodeW-1:0] opImm = 7'b0010011;
	localparam logic [opcodeW-1:0] opLoad = 7'b0000011;
	localparam logic [opcodeW-1:0] opStore = 7'b0100011;
	localparam logic [opcodeW-1:0] opBranch = 7'b1100011;
	localparam logic [opcodeW-1:0] opLui = 7'b0110111;

	// funct3 codes
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Srl = 3'b101;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Word = 3'b010;

	localparam logic [6:0] funct7Base = 7'b0000000;
	localparam logic [6:0] funct7Sub = 7'b0100000;

	// alu operations
	localparam logic [aluOpW-1:0] aluAdd = 4'd0;
	localparam logic [aluOpW-1:0] aluSub = 4'd1;
	localparam logic [aluOpW-1:0] aluAnd = 4'd2;
	localparam logic [aluOpW-1:0] aluOr = 4'd3;
	localparam logic [aluOpW-1:0] aluXor = 4'd4;
	localparam logic [aluOpW-1:0] aluSlt = 4'd5;
	localparam logic [aluOpW-1:0] aluSll = 4'd6;
	localparam logic [aluOpW-1:0] aluSrl = 4'd7;
	localparam logic [aluOpW-1:0] aluPassB = 4'd8;

	// branch kinds
	localparam logic [brKindW-1:0] brNone = 2'd0;
	localparam logic [brKindW-1:0] brEq = 2'd1;
	localparam logic [brKindW-1:0] brNe = 2'd2;

	// one instruction word, four field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0] funct3;
			logic [regAddrW-1:0] rd;
			logic [opcodeW-1:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm12;
			logic [regAddrW-1:0] rs1;
			logic [2:0] funct3;
			logic [regAddrW-1:0] rd;
			logic [opcodeW-1:0] opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [opcodeW-1:0] opcode;
		} sType;
		struct packed {
			logic immBit12;
			logic [5:0] immBits10to5;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0] funct3;
			// bits 4:1 of the offset, then bit 11
			logic [4:0] immLo;
			logic [opcodeW-1:0] opcode;
		} bType;
	} rvInst;

endpackage

//--- tbRvCore.sv
module tbRvCore;

	localparam int numTests = 6;
	localparam int resetCycles = 16;
	// instruction counts of the six programs, in run order
	localparam int programTotal = 14 + 6 + 11 + 18 + 102 + 78;
	localparam int cycleLimit = 2 * programTotal + numTests * resetCycles + 100 * numTests;

	logic clk;
	logic rstN;
	logic [31:0] imemData;
	logic [31:0] imemAddr;
	logic dmemWriteEn;
	logic [31:0] dmemWriteAddr;
	logic [31:0] dmemWriteData;
	logic wbEn;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	logic [31:0] imem [256];
	logic [31:0] refRegs [32];
	logic [31:0] refMem [256];
	logic [31:0] refPc;
	int progLen;
	int errors;
	int checks;
	int cycleCount = 0;

	rvCore UUT (
		.clk           (clk),
		.rstN          (rstN),
		.imemData      (imemData),
		.imemAddr      (imemAddr),
		.dmemWriteEn   (dmemWriteEn),
		.dmemWriteAddr (dmemWriteAddr),
		.dmemWriteData (dmemWriteData),
		.wbEn          (wbEn),
		.wbAddr        (wbAddr),
		.wbData        (wbData)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic put(input logic [31:0] word);
		imem[progLen[7:0]] = word;
		progLen++;
	endtask

	task automatic regOp(input string m, input int rd, input int rs1, input int rs2);
		logic [6:0] f7;
		logic [2:0] f3;
		f7 = 7'h00;
		case (m)
			"sub": begin
				f3 = 3'd0;
				f7 = 7'h20;
			end
			"sll": f3 = 3'd1;
			"slt": f3 = 3'd2;
			"xor": f3 = 3'd4;
			"srl": f3 = 3'd5;
			"or": f3 = 3'd6;
			"and": f3 = 3'd7;
			default: f3 = 3'd0;
		endcase
		put({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011});
	endtask

	task automatic immOp(input string m, input int rd, input int rs1, input logic [31:0] imm);
		logic [2:0] f3;
		case (m)
			"slti": f3 = 3'd2;
			"xori": f3 = 3'd4;
			"ori": f3 = 3'd6;
			"andi": f3 = 3'd7;
			default: f3 = 3'd0;
		endcase
		put({imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011});
	endtask

	task automatic loadWord(input int rd, input int rs1, input int off);
		put({off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011});
	endtask

	task automatic storeWord(input int rs2, input int rs1, input int off);
		put({off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011});
	endtask

	task automatic branch(input string m, input int rs1, input int rs2, input int off);
		logic [2:0] f3;
		f3 = (m == "bne") ? 3'd1 : 3'd0;
		put({off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011});
	endtask

	task automatic loadUpper(input int rd, input logic [19:0] upper);
		put({upper, rd[4:0], 7'b0110111});
	endtask

	// lui rounds up when the low part is negative
	task automatic loadConst(input int rd, input logic [31:0] v);
		logic [31:0] upper;
		upper = (v + 32'h800) >> 12;
		loadUpper(rd, upper[19:0]);
		immOp("addi", rd, rd, v);
	endtask

	task automatic restartCore;
		rstN = 1'b0;
		imemData = '0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
	endtask

	// one instruction per call, entered and left on a falling edge
	task automatic executeCycle;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] addr;
		logic [31:0] res;
		logic [31:0] nextPc;
		logic [4:0] rd;
		logic [2:0] f3;
		logic wr;
		logic st;
		checkValue("imemAddr", refPc, imemAddr);
		imemData = imem[imemAddr[9:2]];
		inst = imem[refPc[9:2]];
		rd = inst[11:7];
		f3 = inst[14:12];
		a = refRegs[inst[19:15]];
		b = refRegs[inst[24:20]];
		immI = {{20{inst[31]}}, inst[31:20]};
		immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		wr = 1'b0;
		st = 1'b0;
		res = '0;
		addr = '0;
		nextPc = refPc + 32'd4;
		case (inst[6:0])
			7'b0110011: begin
				wr = 1'b1;
				case ({inst[31:25], f3})
					{7'h00, 3'd0}: res = a + b;
					{7'h20, 3'd0}: res = a - b;
					{7'h00, 3'd1}: res = a << b[4:0];
					{7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					{7'h00, 3'd4}: res = a ^ b;
					{7'h00, 3'd5}: res = a >> b[4:0];
					{7'h00, 3'd6}: res = a | b;
					{7'h00, 3'd7}: res = a & b;
					default: wr = 1'b0;
				endcase
			end
			7'b0010011: begin
				wr = 1'b1;
				case (f3)
					3'd0: res = a + immI;
					3'd2: res = ($signed(a) < $signed(immI)) ? 32'd1 : 32'd0;
					3'd4: res = a ^ immI;
					3'd6: res = a | immI;
					3'd7: res = a & immI;
					default: wr = 1'b0;
				endcase
			end
			7'b0000011: begin
				addr = a + immI;
				wr = (f3 == 3'd2);
				res = refMem[addr[9:2]];
			end
			7'b0100011: begin
				addr = a + immS;
				st = (f3 == 3'd2);
			end
			7'b1100011: begin
				if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
					nextPc = refPc + immB;
				end
			end
			7'b0110111: begin
				wr = 1'b1;
				res = {inst[31:12], 12'b0};
			end
			default: begin
			end
		endcase
		wr = wr && (rd != 5'd0);
		#10;
		checkValue("wbEn", {31'b0, wr}, {31'b0, wbEn});
		if (wr) begin
			checkValue("wbAddr", {27'b0, rd}, {27'b0, wbAddr});
			checkValue("wbData", res, wbData);
		end
		checkValue("dmemWriteEn", {31'b0, st}, {31'b0, dmemWriteEn});
		if (st) begin
			checkValue("dmemWriteAddr", addr, dmemWriteAddr);
			checkValue("dmemWriteData", b, dmemWriteData);
		end
		if (wr) begin
			refRegs[rd] = res;
		end
		if (st) begin
			refMem[addr[9:2]] = b;
		end
		refPc = nextPc;
		@(negedge clk);
	endtask

	task automatic runProgram;
		logic [31:0] endPc;
		endPc = 32'(progLen) << 2;
		restartCore();
		refPc = '0;
		while (refPc != endPc) begin
			executeCycle();
		end
		checkValue("imemAddr", endPc, imemAddr);
	endtask

	task automatic testArithLogic;
		progLen = 0;
		immOp("addi", 1, 0, 100);
		immOp("addi", 2, 0, -37);
		regOp("add", 3, 1, 2);
		regOp("sub", 4, 1, 2);
		regOp("and", 5, 1, 2);
		regOp("or", 6, 1, 2);
		regOp("xor", 7, 1, 2);
		regOp("slt", 8, 2, 1);
		regOp("slt", 9, 1, 2);
		immOp("andi", 10, 2, 32'h0f0);
		immOp("ori", 11, 1, -256);
		immOp("xori", 12, 2, 32'h555);
		immOp("slti", 13, 2, -36);
		immOp("slti", 14, 1, 5);
		runProgram();
	endtask

	task automatic testRegZero;
		progLen = 0;
		immOp("addi", 0, 0, 55);
		regOp("add", 0, 1, 2);
		loadUpper(0, 20'h12345);
		regOp("add", 15, 0, 0);
		regOp("or", 16, 1, 0);
		immOp("addi", 17, 0, -1);
		runProgram();
	endtask

	task automatic testStoreLoad;
		progLen = 0;
		immOp("addi", 20, 0, 32'h40);
		immOp("addi", 21, 0, 32'h5a5);
		loadConst(22, 32'hdead07ef);
		storeWord(21, 20, 0);
		storeWord(22, 20, 8);
		storeWord(1, 20, -4);
		loadWord(23, 20, 0);
		loadWord(24, 20, 8);
		loadWord(25, 20, -4);
		regOp("add", 26, 23, 24);
		runProgram();
	endtask

	task automatic testBranches;
		progLen = 0;
		immOp("addi", 27, 0, 3);
		immOp("addi", 28, 0, 0);
		immOp("addi", 28, 28, 5);
		immOp("addi", 27, 27, -1);
		branch("bne", 27, 0, -8);
		branch("beq", 27, 0, 8);
		immOp("addi", 28, 0, 999);
		branch("beq", 28, 0, 8);
		branch("bne", 28, 28, 8);
		immOp("addi", 29, 28, 1);
		branch("beq", 29, 29, 8);
		immOp("addi", 29, 0, 0);
		immOp("addi", 30, 0, 0);
		immOp("addi", 30, 30, 1);
		immOp("addi", 31, 30, -2);
		branch("beq", 31, 0, 8);
		branch("beq", 0, 0, -12);
		immOp("addi", 31, 0, 7);
		runProgram();
	endtask

	task automatic testUpperShift;
		progLen = 0;
		loadConst(5, 32'h12345678);
		loadConst(6, 32'h87654edd);
		loadConst(7, 32'hfffff800);
		// odd amounts carry bit 5 set, only the low 5 bits count
		for (int k = 0; k < 32; k++) begin
			immOp("addi", 8, 0, k + 32 * (k % 2));
			regOp("sll", 9, 6, 8);
			regOp("srl", 10, 6, 8);
		end
		runProgram();
	endtask

	task automatic testRandomOps;
		logic [31:0] a;
		logic [31:0] b;
		progLen = 0;
		for (int k = 0; k < 6; k++) begin
			a = $urandom();
			b = $urandom();
			// every other pair gets opposite signs for slt
			if (k % 2 == 0) begin
				b[31] = ~a[31];
			end
			loadConst(11, a);
			loadConst(12, b);
			regOp("add", 13, 11, 12);
			regOp("sub", 14, 11, 12);
			regOp("and", 15, 11, 12);
			regOp("or", 16, 11, 12);
			regOp("xor", 17, 11, 12);
			regOp("slt", 18, 11, 12);
			regOp("slt", 19, 12, 11);
			regOp("sll", 20, 11, 12);
			regOp("srl", 21, 11, 12);
		end
		runProgram();
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		imemData = '0;
		errors = 0;
		checks = 0;
		refRegs[0] = '0;
		void'($urandom(32'h8367_adaa));
		testArithLogic();
		testRegZero();
		testStoreLoad();
		testBranches();
		testUpperShift();
		testRandomOps();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
